// File: compile.f
rtl/soc_pkg.sv
rtl/ps2_rx.sv
rtl/key_decode.sv
rtl/cmd_execute.sv
rtl/seg_result.sv
rtl/soc_top.sv
test/soc_props.sv
test/soc_checker.sv
test/soc_tb.sv

// File: Makefile
# Verilator build and run for the console soc testbench

VERILATOR ?= verilator
TOP       ?= soc_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: test/soc_tb.sv
// console soc testbench: ps2 key stimulus, reference model and test sequence
`timescale 1ns/1ns
`default_nettype none

module soc_tb import soc_pkg::*; ();

    // expected state, prefix flags included
    typedef struct packed {
        logic              brk;
        logic              ext;
        logic [led_w-1:0]  leds;
        logic [disp_w-1:0] disp;
    } model_t;

    logic              clk200m;
    logic              rst;
    logic              ps2_clk;
    logic              ps2_data;
    logic [led_w-1:0]  swt;
    logic [led_w-1:0]  leds;
    logic              seg_clk;
    logic              seg_clr;
    logic              seg_dt;
    logic              seg_en;
    logic              check_stb;
    logic [disp_w-1:0] exp_disp;
    logic [led_w-1:0]  exp_leds;
    int                frame_cnt;
    int                err_cnt;
    model_t            model;
    logic [15:0]       lfsr;
    logic [7:0]        rnd;
    int                timeouts;
    int                tests_run;
    int                tests_failed;
    int                test_base;
    int                prop_fails;

    soc_top DUT (
        .clk200m  (clk200m),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .swt      (swt),
        .leds     (leds),
        .seg_clk  (seg_clk),
        .seg_clr  (seg_clr),
        .seg_dt   (seg_dt),
        .seg_en   (seg_en)
    );

    soc_checker u_checker (
        .clk200m   (clk200m),
        .rst       (rst),
        .seg_clk   (seg_clk),
        .seg_en    (seg_en),
        .seg_dt    (seg_dt),
        .seg_clr   (seg_clr),
        .leds      (leds),
        .check_stb (check_stb),
        .exp_disp  (exp_disp),
        .exp_leds  (exp_leds),
        .frame_cnt (frame_cnt),
        .err_cnt   (err_cnt)
    );

    // 8 ns period
    initial clk200m = 1'b0;
    always #4 clk200m = ~clk200m;

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit
    task automatic draw_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr[15]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // set 2 make code of a hex key
    function automatic logic [7:0] hex_key(input logic [3:0] n);
        logic [7:0] t [16];
        t = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D,
              8'h3E, 8'h46, 8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B};
        return t[n];
    endfunction

    // reverse lookup, {hit, nibble}
    function automatic logic [4:0] key_hex(input logic [7:0] code);
        logic [4:0] r;
        r = '0;
        for (int i = 0; i < 16; i++) begin
            if (hex_key(4'(i)) == code) begin
                r = {1'b1, 4'(i)};
            end
        end
        return r;
    endfunction

    // expected effect of one good byte
    function automatic model_t ref_key(input model_t m, input logic [7:0] code,
                                       input logic [led_w-1:0] sw);
        model_t     r;
        logic [4:0] hx;
        r = m;
        hx = key_hex(code);
        if (code == 8'hF0) begin
            r.brk = 1'b1;
        end else if (code == 8'hE0) begin
            r.ext = 1'b1;
        end else begin
            // byte after a prefix only clears it
            r.brk = 1'b0;
            r.ext = 1'b0;
            if (!m.brk && !m.ext) begin
                if (hx[4]) begin
                    // one hex place up, new digit at the bottom
                    r.disp = (m.disp << 4) | disp_w'(hx[3:0]);
                end else if (code == 8'h5A) begin
                    r.disp = m.disp + disp_w'(sw);
                end else if (code == 8'h4B) begin
                    r.leds = sw;
                end else if (code == 8'h66) begin
                    r.disp = '0;
                    r.leds = '0;
                end
            end
        end
        return r;
    endfunction

    // start, d0..d7, parity, stop; data set while ps2_clk is high
    task automatic send_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk200m);
            ps2_data <= bits[i];
            repeat (10) @(posedge clk200m);
            ps2_clk <= 1'b0;
            repeat (10) @(posedge clk200m);
            ps2_clk <= 1'b1;
        end
        @(posedge clk200m);
        ps2_data <= 1'b1;
        // idle line between frames
        repeat (40) @(posedge clk200m);
    endtask

    // all stage handshakes back to low
    task automatic wait_idle();
        int n;
        n = 0;
        while ((DUT.key_req || DUT.key_ack || DUT.cmd_req || DUT.cmd_ack ||
                DUT.disp_req || DUT.disp_ack) && n < 2000) begin
            @(posedge clk200m);
            n++;
        end
        if (n >= 2000) begin
            $display("The handshakes between the stages did not return to idle");
            timeouts++;
        end
    endtask

    // good frame, model update, then wait for the stages to settle
    task automatic send_key(input logic [7:0] code);
        send_frame(code, 1'b0);
        model = ref_key(model, code, swt);
        wait_idle();
    endtask

    // press and release
    task automatic type_key(input logic [7:0] code);
        send_key(code);
        send_key(8'hF0);
        send_key(code);
    endtask

    task automatic set_switches(input logic [led_w-1:0] v);
        @(posedge clk200m);
        swt <= v;
    endtask

    // one frame is 72 segment bits of 32 clk200m cycles
    task automatic wait_frames(input int n);
        int target;
        int t;
        target = frame_cnt + n;
        t = 0;
        while (frame_cnt < target && t < (n + 1) * 2400) begin
            @(posedge clk200m);
            t++;
        end
        if (frame_cnt < target) begin
            $display("The segment display did not send a complete frame in time");
            timeouts++;
        end
    endtask

    // second frame is the first one started after the latch
    task automatic check_now(input int frames);
        wait_idle();
        wait_frames(frames);
        @(posedge clk200m);
        exp_disp <= model.disp;
        exp_leds <= model.leds;
        check_stb <= 1'b1;
        @(posedge clk200m);
        check_stb <= 1'b0;
        @(posedge clk200m);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_cnt + timeouts != test_base) begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        test_base = err_cnt + timeouts;
    endtask

    initial begin
        rst = 1'b1;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        swt = '0;
        check_stb = 1'b0;
        exp_disp = '0;
        exp_leds = '0;
        model = '0;
        lfsr = 16'd81;
        timeouts = 0;
        tests_run = 0;
        tests_failed = 0;
        test_base = 0;
        repeat (8) @(posedge clk200m);
        rst <= 1'b0;

        // reset state on the first frame
        check_now(1);
        end_test("after reset");

        for (int i = 0; i < 8; i++) begin
            draw_bits(4, rnd);
            type_key(hex_key(rnd[3:0]));
        end
        check_now(2);
        end_test("digit entry");

        for (int i = 0; i < 4; i++) begin
            draw_bits(8, rnd);
            set_switches(rnd);
            type_key(8'h5A);
        end
        check_now(2);
        end_test("enter adds");

        draw_bits(8, rnd);
        set_switches(rnd);
        type_key(8'h4B);
        check_now(2);
        type_key(8'h66);
        check_now(2);
        end_test("l and backspace");

        // nonzero state first
        draw_bits(4, rnd);
        type_key(hex_key(rnd[3:0]));
        draw_bits(8, rnd);
        set_switches(rnd);
        type_key(8'h4B);
        send_frame(hex_key(4'h7), 1'b1);
        wait_idle();
        send_frame(8'h5A, 1'b1);
        wait_idle();
        send_key(8'hE0);
        send_key(hex_key(4'h3));
        send_key(8'hE0);
        send_key(8'hF0);
        send_key(hex_key(4'h3));
        type_key(8'h15);
        check_now(2);
        end_test("ignored input");

        prop_fails = DUT.u_cmd_execute.u_props.fail_cnt;
        $display("%0d tests, %0d failed, %0d errors, %0d timeouts, %0d assertion failures",
                 tests_run, tests_failed, err_cnt, timeouts, prop_fails);
        if (tests_failed == 0 && err_cnt == 0 && timeouts == 0 && prop_fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/soc_checker.sv
// display checker: rebuilds serial segment frames and compares display and leds
`timescale 1ns/1ns
`default_nettype none

module soc_checker import soc_pkg::*; (
    input  wire logic              clk200m,
    input  wire logic              rst,
    input  wire logic              seg_clk,
    input  wire logic              seg_en,
    input  wire logic              seg_dt,
    input  wire logic              seg_clr,
    input  wire logic [led_w-1:0]  leds,
    input  wire logic              check_stb,
    input  wire logic [disp_w-1:0] exp_disp,
    input  wire logic [led_w-1:0]  exp_leds,
    output int                     frame_cnt,
    output int                     err_cnt
);

    logic [63:0] shift;
    logic [63:0] last_frame;
    int          bit_cnt = 0;
    int          frames = 0;
    int          errors = 0;

    assign frame_cnt = frames;
    assign err_cnt = errors;

    // active low {dp,g,f,e,d,c,b,a} back to {valid, nibble}
    function automatic logic [4:0] seg_to_nib(input logic [7:0] pat);
        case (pat)
            8'b1100_0000: return 5'h10;
            8'b1111_1001: return 5'h11;
            8'b1010_0100: return 5'h12;
            8'b1011_0000: return 5'h13;
            8'b1001_1001: return 5'h14;
            8'b1001_0010: return 5'h15;
            8'b1000_0010: return 5'h16;
            8'b1111_1000: return 5'h17;
            8'b1000_0000: return 5'h18;
            8'b1001_0000: return 5'h19;
            8'b1000_1000: return 5'h1A;
            8'b1000_0011: return 5'h1B;
            8'b1100_0110: return 5'h1C;
            8'b1010_0001: return 5'h1D;
            8'b1000_0110: return 5'h1E;
            8'b1000_1110: return 5'h1F;
            default:      return 5'h00;
        endcase
    endfunction

    // whole frame to {all digits valid, value}, digit 7 in the top byte
    function automatic logic [32:0] decode_frame(input logic [63:0] f);
        logic [32:0] r;
        logic [4:0]  d;
        r = {1'b1, 32'h0};
        for (int i = 0; i < 8; i++) begin
            d = seg_to_nib(f[i*8 +: 8]);
            r[i*4 +: 4] = d[3:0];
            if (!d[4]) begin
                r[32] = 1'b0;
            end
        end
        return r;
    endfunction

    // msb first, sampled on rising seg_clk while seg_en is high
    always @(posedge seg_clk) begin
        if (seg_en) begin
            if (bit_cnt == 63) begin
                last_frame <= {shift[62:0], seg_dt};
                frames <= frames + 1;
                bit_cnt <= 0;
            end else begin
                shift <= {shift[62:0], seg_dt};
                bit_cnt <= bit_cnt + 1;
            end
        end else begin
            // gap between frames
            bit_cnt <= 0;
        end
    end

    // compare on the strobe from the testbench
    always @(posedge clk200m) begin
        logic [32:0] dec;
        // display held cleared for as long as reset is high
        if (rst && seg_clr !== 1'b0) begin
            $display("Fail at %0t ns: seg_clr expected 0, got %b", $time, seg_clr);
            errors = errors + 1;
        end
        if (check_stb) begin
            dec = decode_frame(last_frame);
            if (frames == 0) begin
                $display("No complete segment frame had arrived when the display was checked");
                errors = errors + 1;
            end else if (!dec[32]) begin
                $display("Segment frame %h holds a pattern that is not a hex digit",
                         last_frame);
                errors = errors + 1;
            end else if (dec[31:0] !== exp_disp) begin
                $display("Fail at %0t ns: display value expected %h, got %h",
                         $time, exp_disp, dec[31:0]);
                errors = errors + 1;
            end
            if (leds !== exp_leds) begin
                $display("Fail at %0t ns: leds expected %h, got %h", $time, exp_leds, leds);
                errors = errors + 1;
            end
            if (seg_clr !== 1'b1) begin
                $display("Fail at %0t ns: seg_clr expected 1, got %b", $time, seg_clr);
                errors = errors + 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: test/soc_props.sv
// executor handshake properties: req/ack ordering and idle state around reset
`timescale 1ns/1ns
`default_nettype none

module soc_props (
    input wire logic clk200m,
    input wire logic rst,
    input wire logic cmd_req,
    input wire logic cmd_ack,
    input wire logic disp_req,
    input wire logic disp_ack
);

    // failures seen so far, read back by the testbench
    int fail_cnt = 0;

    // decoder holds cmd_req until the executor acks
    cmd_req_hold: assert property (@(posedge clk200m) disable iff (rst)
        cmd_req && !cmd_ack |=> cmd_req)
        else begin
            $error("cmd_req dropped before cmd_ack rose");
            fail_cnt++;
        end

    // executor holds disp_req until the display acks
    disp_req_hold: assert property (@(posedge clk200m) disable iff (rst)
        disp_req && !disp_ack |=> disp_req)
        else begin
            $error("disp_req dropped before disp_ack rose");
            fail_cnt++;
        end

    // ack stays up while req is still high
    cmd_ack_hold: assert property (@(posedge clk200m) disable iff (rst)
        cmd_ack && cmd_req |=> cmd_ack)
        else begin
            $error("cmd_ack fell while cmd_req was high");
            fail_cnt++;
        end

    disp_ack_hold: assert property (@(posedge clk200m) disable iff (rst)
        disp_ack && disp_req |=> disp_ack)
        else begin
            $error("disp_ack fell while disp_req was high");
            fail_cnt++;
        end

    // first free-running cycle after reset, nothing has started yet
    reset_idle: assert property (@(posedge clk200m)
        $fell(rst) |=> !cmd_req && !cmd_ack && !disp_req && !disp_ack)
        else begin
            $error("handshake line high just after reset");
            fail_cnt++;
        end

endmodule

bind cmd_execute soc_props u_props (.*);

`default_nettype wire

// File: rtl/soc_top.sv
// console soc top: ps2 keys to commands, executor, leds and serial segment display
`timescale 1ns/1ns
`default_nettype none

module soc_top import soc_pkg::*; (
    input  wire logic             clk200m,
    input  wire logic             rst,
    input  wire logic             ps2_clk,
    input  wire logic             ps2_data,
    input  wire logic [led_w-1:0] swt,
    output logic [led_w-1:0]      leds,
    output logic                  seg_clk,
    output logic                  seg_clr,
    output logic                  seg_dt,
    output logic                  seg_en
);

    // receiver to decoder
    logic              key_req;
    logic              key_ack;
    logic [7:0]        key_code;
    // decoder to executor
    logic              cmd_req;
    logic              cmd_ack;
    cmd_t              cmd;
    // executor to display
    logic              disp_req;
    logic              disp_ack;
    logic [disp_w-1:0] disp_value;

    ps2_rx u_ps2_rx (
        .clk200m  (clk200m),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .key_ack  (key_ack),
        .key_req  (key_req),
        .key_code (key_code)
    );

    key_decode u_key_decode (
        .clk200m  (clk200m),
        .rst      (rst),
        .key_req  (key_req),
        .key_code (key_code),
        .cmd_ack  (cmd_ack),
        .key_ack  (key_ack),
        .cmd_req  (cmd_req),
        .cmd      (cmd)
    );

    cmd_execute u_cmd_execute (
        .clk200m    (clk200m),
        .rst        (rst),
        .swt        (swt),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .disp_ack   (disp_ack),
        .cmd_ack    (cmd_ack),
        .leds       (leds),
        .disp_req   (disp_req),
        .disp_value (disp_value)
    );

    seg_result u_seg_result (
        .clk200m    (clk200m),
        .rst        (rst),
        .disp_req   (disp_req),
        .disp_value (disp_value),
        .disp_ack   (disp_ack),
        .seg_clk    (seg_clk),
        .seg_clr    (seg_clr),
        .seg_dt     (seg_dt),
        .seg_en     (seg_en)
    );

endmodule

`default_nettype wire

// File: rtl/seg_result.sv
// result stage: latches the display value and shifts segment frames out serially
`timescale 1ns/1ns
`default_nettype none

module seg_result import soc_pkg::*; (
    input  wire logic              clk200m,
    input  wire logic              rst,
    input  wire logic              disp_req,
    input  wire logic [disp_w-1:0] disp_value,
    output logic                   disp_ack,
    output logic                   seg_clk,
    output logic                   seg_clr,
    output logic                   seg_dt,
    output logic                   seg_en
);

    localparam int frame_bits = seg_digits * 8;
    // 64 data bits plus an 8-period gap
    localparam int period_bits = frame_bits + 8;
    localparam int pos_w = $clog2(period_bits);

    logic [disp_w-1:0]     shown;
    logic [frame_bits-1:0] frame;
    logic [frame_bits-1:0] shreg;
    logic [seg_div_w-1:0]  div_cnt;
    logic [pos_w-1:0]      pos;
    logic                  seg_fall;

    // active low {dp,g,f,e,d,c,b,a}, dp held off
    function automatic logic [7:0] seg_pat(input logic [3:0] nib);
        case (nib)
            4'h0: return 8'hC0;
            4'h1: return 8'hF9;
            4'h2: return 8'hA4;
            4'h3: return 8'hB0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hF8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'hA: return 8'h88;
            4'hB: return 8'h83;
            4'hC: return 8'hC6;
            4'hD: return 8'hA1;
            4'hE: return 8'h86;
            default: return 8'h8E;
        endcase
    endfunction

    // digit 7 lands in the top byte, so it goes out first
    always_comb begin
        for (int d = 0; d < seg_digits; d++) begin
            frame[d*8 +: 8] = seg_pat(shown[d*4 +: 4]);
        end
    end

    // seg_clk about to go low, data changes here
    assign seg_fall = (div_cnt == '1) && seg_clk;

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            shown    <= '0;
            disp_ack <= 1'b0;
            div_cnt  <= '0;
            seg_clk  <= 1'b0;
            seg_clr  <= 1'b0;
            seg_dt   <= 1'b1;
            seg_en   <= 1'b0;
            pos      <= '0;
        end else begin
            seg_clr <= 1'b1;
            div_cnt <= div_cnt + 1'b1;
            // latch and ack, the shifter picks it up at the next frame
            if (disp_req && !disp_ack) begin
                shown    <= disp_value;
                disp_ack <= 1'b1;
            end else if (!disp_req && disp_ack) begin
                disp_ack <= 1'b0;
            end
            if (div_cnt == '1) begin
                seg_clk <= ~seg_clk;
            end
            if (seg_fall) begin
                if (pos == 0) begin
                    seg_dt <= frame[frame_bits-1];
                    seg_en <= 1'b1;
                end else if (pos < pos_w'(frame_bits)) begin
                    seg_dt <= shreg[frame_bits-1];
                end else if (pos == pos_w'(frame_bits)) begin
                    seg_en <= 1'b0;
                end
                pos <= (pos == pos_w'(period_bits - 1)) ? '0 : pos + 1'b1;
            end
        end
    end

    // frame shifter
    always_ff @(posedge clk200m) begin
        if (seg_fall) begin
            if (pos == 0) begin
                shreg <= {frame[frame_bits-2:0], 1'b0};
            end else begin
                shreg <= {shreg[frame_bits-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/cmd_execute.sv
// command executor: owns the display value and led register
`timescale 1ns/1ns
`default_nettype none

module cmd_execute import soc_pkg::*; (
    input  wire logic              clk200m,
    input  wire logic              rst,
    input  wire logic [led_w-1:0]  swt,
    input  wire logic              cmd_req,
    input  cmd_t                   cmd,
    input  wire logic              disp_ack,
    output logic                   cmd_ack,
    output logic [led_w-1:0]       leds,
    output logic                   disp_req,
    output logic [disp_w-1:0]      disp_value
);

    // idle, waiting for disp ack, waiting for disp ack low, acking cmd
    typedef enum logic [1:0] {
        st_idle,
        st_disp,
        st_drop,
        st_ack
    } exe_st_e;

    exe_st_e state;

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            state      <= st_idle;
            cmd_ack    <= 1'b0;
            disp_req   <= 1'b0;
            disp_value <= '0;
            leds       <= '0;
        end else begin
            unique case (state)
                st_idle: begin
                    if (cmd_req) begin
                        unique case (cmd.op)
                            op_digit: disp_value <= {disp_value[disp_w-5:0], cmd.nib};
                            // zero-extended switches, wraps mod 2^32
                            op_add:   disp_value <= disp_value +
                                          {{(disp_w-led_w){1'b0}}, swt};
                            op_led:   leds <= swt;
                            op_clear: begin
                                disp_value <= '0;
                                leds       <= '0;
                            end
                        endcase
                        // every command refreshes the display, even op_led
                        disp_req <= 1'b1;
                        state    <= st_disp;
                    end
                end
                st_disp: begin
                    if (disp_ack) begin
                        disp_req <= 1'b0;
                        state    <= st_drop;
                    end
                end
                st_drop: begin
                    // display side closed its half, now finish the command
                    if (!disp_ack) begin
                        cmd_ack <= 1'b1;
                        state   <= st_ack;
                    end
                end
                st_ack: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= st_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/key_decode.sv
// key decoder: turns scan bytes into executor commands, skipping prefixes
`timescale 1ns/1ns
`default_nettype none

module key_decode import soc_pkg::*; (
    input  wire logic       clk200m,
    input  wire logic       rst,
    input  wire logic       key_req,
    input  wire logic [7:0] key_code,
    input  wire logic       cmd_ack,
    output logic            key_ack,
    output logic            cmd_req,
    output cmd_t            cmd
);

    // prefix state
    logic       brk_seen;
    logic       ext_seen;
    logic       accept;
    logic [4:0] hex_hit;

    // {hit, nibble} for a hex key
    function automatic logic [4:0] hex_lookup(input logic [7:0] code);
        logic [4:0] r;
        r = '0;
        for (int i = 0; i < 16; i++) begin
            if (sc_hex[i] == code) begin
                r = {1'b1, 4'(i)};
            end
        end
        return r;
    endfunction

    assign hex_hit = hex_lookup(key_code);

    // take a byte only with the downstream handshake fully closed
    assign accept = key_req && !key_ack && !cmd_req && !cmd_ack;

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            key_ack  <= 1'b0;
            cmd_req  <= 1'b0;
            brk_seen <= 1'b0;
            ext_seen <= 1'b0;
        end else begin
            if (key_ack && !key_req) begin
                key_ack <= 1'b0;
            end
            if (cmd_req && cmd_ack) begin
                cmd_req <= 1'b0;
            end
            if (accept) begin
                key_ack <= 1'b1;
                if (key_code == sc_break) begin
                    brk_seen <= 1'b1;
                end else if (key_code == sc_ext) begin
                    ext_seen <= 1'b1;
                end else begin
                    // byte after F0 or E0 is swallowed
                    brk_seen <= 1'b0;
                    ext_seen <= 1'b0;
                    if (!brk_seen && !ext_seen &&
                        (hex_hit[4] || key_code == sc_enter ||
                         key_code == sc_l || key_code == sc_bksp)) begin
                        cmd_req <= 1'b1;
                    end
                end
            end
        end
    end

    // command payload, loaded on every accept and ignored unless cmd_req rises
    always_ff @(posedge clk200m) begin
        if (accept) begin
            cmd.nib <= hex_hit[3:0];
            if (hex_hit[4]) begin
                cmd.op <= op_digit;
            end else if (key_code == sc_enter) begin
                cmd.op <= op_add;
            end else if (key_code == sc_l) begin
                cmd.op <= op_led;
            end else begin
                cmd.op <= op_clear;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/ps2_rx.sv
// ps2 receiver: synchronizes the keyboard lines and hands on good frame bytes
`timescale 1ns/1ns
`default_nettype none

module ps2_rx (
    input  wire logic       clk200m,
    input  wire logic       rst,
    input  wire logic       ps2_clk,
    input  wire logic       ps2_data,
    input  wire logic       key_ack,
    output logic            key_req,
    output logic [7:0]      key_code
);

    // two-flop synchronizers plus one extra stage on clk for edge detect
    logic [2:0]  clk_sync;
    logic [1:0]  dat_sync;
    logic        ps2_fall;
    logic        ps2_d;

    // frame shifter, lsb first: start, d0..d7, parity, stop
    logic [10:0] shreg;
    logic [10:0] shreg_nxt;
    logic [3:0]  bit_cnt;
    logic        frame_ok;

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            clk_sync <= 3'b111;
            dat_sync <= 2'b11;
        end else begin
            clk_sync <= {clk_sync[1:0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_data};
        end
    end

    assign ps2_d = dat_sync[1];
    // high-to-low on the synchronized clock
    assign ps2_fall = clk_sync[2] & ~clk_sync[1];

    // frame as it looks once the current bit is in
    assign shreg_nxt = {ps2_d, shreg[10:1]};

    // start low, stop high, odd parity over data and parity bit
    assign frame_ok = ~shreg_nxt[0] & shreg_nxt[10] & (^shreg_nxt[9:1]);

    // shifter is payload only
    always_ff @(posedge clk200m) begin
        if (ps2_fall) begin
            shreg <= shreg_nxt;
        end
    end

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            bit_cnt <= '0;
            key_req <= 1'b0;
        end else begin
            if (ps2_fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt <= '0;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
            // drop req once the decoder has taken the byte
            if (key_req && key_ack) begin
                key_req <= 1'b0;
            end else if (ps2_fall && bit_cnt == 4'd10 && frame_ok
                         && !key_req && !key_ack) begin
                // handshake still open means the byte is lost
                key_req <= 1'b1;
            end
        end
    end

    // byte register, written only when a new req goes up
    always_ff @(posedge clk200m) begin
        if (ps2_fall && bit_cnt == 4'd10 && frame_ok && !key_req && !key_ack) begin
            key_code <= shreg_nxt[8:1];
        end
    end

endmodule

`default_nettype wire

// File: rtl/soc_pkg.sv
// console soc package: widths, scan codes and the decoder command type
`default_nettype none

package soc_pkg;

    // display value and led/switch widths
    localparam int disp_w = 32;
    localparam int led_w = 8;

    // segment display geometry and pacing
    localparam int seg_digits = 8;
    // 4-bit divider, seg_clk toggles on wrap, so clk200m/32
    localparam int seg_div_w = 4;

    // set 2 scan codes for the hex keys
    localparam logic [7:0] sc_0 = 8'h45;
    localparam logic [7:0] sc_1 = 8'h16;
    localparam logic [7:0] sc_2 = 8'h1E;
    localparam logic [7:0] sc_3 = 8'h26;
    localparam logic [7:0] sc_4 = 8'h25;
    localparam logic [7:0] sc_5 = 8'h2E;
    localparam logic [7:0] sc_6 = 8'h36;
    localparam logic [7:0] sc_7 = 8'h3D;
    localparam logic [7:0] sc_8 = 8'h3E;
    localparam logic [7:0] sc_9 = 8'h46;
    localparam logic [7:0] sc_a = 8'h1C;
    localparam logic [7:0] sc_b = 8'h32;
    localparam logic [7:0] sc_c = 8'h21;
    localparam logic [7:0] sc_d = 8'h23;
    localparam logic [7:0] sc_e = 8'h24;
    localparam logic [7:0] sc_f = 8'h2B;

    // index i holds the code of hex digit i
    localparam logic [15:0][7:0] sc_hex = {
        sc_f, sc_e, sc_d, sc_c, sc_b, sc_a, sc_9, sc_8,
        sc_7, sc_6, sc_5, sc_4, sc_3, sc_2, sc_1, sc_0
    };

    // control keys and prefixes
    localparam logic [7:0] sc_enter = 8'h5A;
    localparam logic [7:0] sc_l = 8'h4B;
    localparam logic [7:0] sc_bksp = 8'h66;
    localparam logic [7:0] sc_break = 8'hF0;
    localparam logic [7:0] sc_ext = 8'hE0;

    // executor operations
    typedef enum logic [1:0] {
        op_digit = 2'd0,
        op_add   = 2'd1,
        op_led   = 2'd2,
        op_clear = 2'd3
    } cmd_op_e;

    // decoder to executor payload, nibble only meaningful for op_digit
    typedef struct packed {
        cmd_op_e    op;
        logic [3:0] nib;
    } cmd_t;

endpackage

`default_nettype wire
